//--- hw/mult_pkg.sv
/*
 * Signed sequential multiplier, shared definitions
 * Widths for operands, product and sweep counter, plus the
 * control FSM state encoding used by the sequencer
 */

package mult_pkg;

	// ========================================
	// Widths
	// ========================================

	// Operand width, both inputs are two's complement of this size
	localparam int DW = 8;

	// Product width, wide enough for -128 * -128 without overflow
	localparam int PW = 2 * DW;

	// Sweep counter width, it only has to reach DW-1
	localparam int CW = $clog2(DW);

	// ========================================
	// Control states
	// ========================================

	// IDLE waits for start, CAPTURE clears the datapath,
	// SWEEP scans one multiplier bit per cycle, FIX applies the sign
	// and DONE raises the one-cycle done pulse
	typedef enum logic [2:0]
	{
		IDLE    = 3'd0,
		CAPTURE = 3'd1,
		SWEEP   = 3'd2,
		FIX     = 3'd3,
		DONE    = 3'd4
	} ctrl_state_e;

endpackage

//--- hw/mult_control_unit.sv
/*
 * Multiplier control unit
 * Sequences capture, sweep, sign fix and done for one product
 * and drops any start request that arrives while busy
 */

`timescale 1ns/10ps

module mult_control_unit
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic sweep_end,
	output logic capture,
	output logic clear,
	output logic enable,
	output logic hold,
	output logic fix,
	output logic busy,
	output logic done
);

	mult_pkg::ctrl_state_e state;
	mult_pkg::ctrl_state_e state_next;

	// ========================================
	// State register
	// ========================================

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			state <= mult_pkg::IDLE;
		else
			state <= state_next;
	end

	// ========================================
	// Next state
	// ========================================

	always_comb
	begin
		state_next = state;
		case (state)
			// Only an idle unit accepts a request
			mult_pkg::IDLE:    if (start) state_next = mult_pkg::CAPTURE;
			mult_pkg::CAPTURE: state_next = mult_pkg::SWEEP;
			// Leave once the adder reports its last bit
			mult_pkg::SWEEP:   if (sweep_end) state_next = mult_pkg::FIX;
			mult_pkg::FIX:     state_next = mult_pkg::DONE;
			mult_pkg::DONE:    state_next = mult_pkg::IDLE;
			default:           state_next = mult_pkg::IDLE;
		endcase
	end

	// ========================================
	// Strobes
	// ========================================

	// Operands are only valid alongside start, so capture follows the accepted request
	assign capture = (state == mult_pkg::IDLE) && start;

	// The datapath is cleared once the magnitudes have been stored
	assign clear = (state == mult_pkg::CAPTURE);

	// Sweep runs only in SWEEP, everywhere else the sum is held still
	assign enable = (state == mult_pkg::SWEEP);
	assign hold   = (state != mult_pkg::SWEEP);

	assign fix  = (state == mult_pkg::FIX);
	assign done = (state == mult_pkg::DONE);

	// Busy covers every state after acceptance, up to and including DONE
	assign busy = (state != mult_pkg::IDLE);

endmodule

//--- hw/sign_resolver.sv
/*
 * Sign resolver
 * Splits the signed operands into magnitudes and a result sign,
 * then negates the unsigned sum when needed and holds the product
 */

`timescale 1ns/10ps

module sign_resolver
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            capture,
	input  logic                            fix,
	input  logic signed [mult_pkg::DW-1:0]  op_a,
	input  logic signed [mult_pkg::DW-1:0]  op_b,
	input  logic        [mult_pkg::PW-1:0]  sum,
	output logic        [mult_pkg::DW-1:0]  mag_a,
	output logic        [mult_pkg::DW-1:0]  mag_b,
	output logic signed [mult_pkg::PW-1:0]  product
);

	// Result sign, set when exactly one operand is negative
	logic neg;

	// ========================================
	// Capture
	// ========================================

	// Two's complement of -128 gives 8'h80, which reads as 128 unsigned
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			mag_a <= op_a[mult_pkg::DW-1] ? (~op_a + 1'b1) : op_a;
			mag_b <= op_b[mult_pkg::DW-1] ? (~op_b + 1'b1) : op_b;
			neg   <= op_a[mult_pkg::DW-1] ^ op_b[mult_pkg::DW-1];
		end
	end

	// ========================================
	// Sign fix and result hold
	// ========================================

	// Product only changes on fix, so it stays readable between operations
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			product <= '0;
		else if (fix)
		begin
			if (neg)
				product <= ~sum + 1'b1;
			else
				product <= sum;
		end
	end

endmodule

//--- hw/operand_register.sv
/*
 * Operand register
 * Holds the multiplicand magnitude at product width and shifts
 * it left once per sweep step to follow the multiplier bit weight
 */

`timescale 1ns/10ps

module operand_register
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     clear,
	input  logic                     enable,
	input  logic [mult_pkg::DW-1:0]  mag_b,
	output logic [mult_pkg::PW-1:0]  shifted_b
);

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			shifted_b <= '0;
		// Load unshifted so the first sweep step adds weight one
		else if (clear)
			shifted_b <= {{(mult_pkg::PW-mult_pkg::DW){1'b0}}, mag_b};
		// Every enabled edge moves on to the next bit weight
		else if (enable)
			shifted_b <= {shifted_b[mult_pkg::PW-2:0], 1'b0};
	end

endmodule

//--- hw/sweep_sequential_adder.sv
/*
 * Sweep sequential adder
 * Walks the multiplier magnitude one bit per cycle and adds the
 * shifted multiplicand wherever that bit is set
 */

`timescale 1ns/10ps

module sweep_sequential_adder
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     clear,
	input  logic                     enable,
	input  logic                     hold,
	input  logic [mult_pkg::DW-1:0]  mag_a,
	input  logic [mult_pkg::PW-1:0]  shifted_b,
	output logic [mult_pkg::PW-1:0]  sum,
	output logic                     sweep_end
);

	// Index of the multiplier bit under inspection
	logic [mult_pkg::CW-1:0] count;

	// ========================================
	// Accumulator and bit counter
	// ========================================

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			count <= '0;
			sum   <= '0;
		end
		else if (clear)
		begin
			count <= '0;
			sum   <= '0;
		end
		// Held outside the sweep, sum stays put and the counter rewinds
		else if (hold)
			count <= '0;
		else if (enable)
		begin
			if (mag_a[count])
				sum <= sum + shifted_b;
			// Stop on the top bit, the control unit moves on from here
			if (count != mult_pkg::CW'(mult_pkg::DW-1))
				count <= count + 1'b1;
		end
	end

	// High during the last sweep cycle, while the top bit is being added
	assign sweep_end = enable && !hold && (count == mult_pkg::CW'(mult_pkg::DW-1));

endmodule

//--- hw/seq_multiplier_top.sv
/*
 * Signed sequential multiplier top level
 * Connects the control unit to the sign resolver, operand register
 * and sweep adder
 */

`timescale 1ns/10ps

module seq_multiplier_top
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            start,
	input  logic signed [mult_pkg::DW-1:0]  op_a,
	input  logic signed [mult_pkg::DW-1:0]  op_b,
	output logic                            busy,
	output logic                            done,
	output logic signed [mult_pkg::PW-1:0]  product
);

	// Control strobes
	logic capture;
	logic clear;
	logic enable;
	logic hold;
	logic fix;
	logic sweep_end;

	// Datapath
	logic [mult_pkg::DW-1:0] mag_a;
	logic [mult_pkg::DW-1:0] mag_b;
	logic [mult_pkg::PW-1:0] shifted_b;
	logic [mult_pkg::PW-1:0] sum;

	mult_control_unit mult_control_unit_i
	(
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.sweep_end (sweep_end),
		.capture   (capture),
		.clear     (clear),
		.enable    (enable),
		.hold      (hold),
		.fix       (fix),
		.busy      (busy),
		.done      (done)
	);

	sign_resolver sign_resolver_i
	(
		.clk     (clk),
		.rst     (rst),
		.capture (capture),
		.fix     (fix),
		.op_a    (op_a),
		.op_b    (op_b),
		.sum     (sum),
		.mag_a   (mag_a),
		.mag_b   (mag_b),
		.product (product)
	);

	operand_register operand_register_i
	(
		.clk       (clk),
		.rst       (rst),
		.clear     (clear),
		.enable    (enable),
		.mag_b     (mag_b),
		.shifted_b (shifted_b)
	);

	sweep_sequential_adder sweep_sequential_adder_i
	(
		.clk       (clk),
		.rst       (rst),
		.clear     (clear),
		.enable    (enable),
		.hold      (hold),
		.mag_a     (mag_a),
		.shifted_b (shifted_b),
		.sum       (sum),
		.sweep_end (sweep_end)
	);

endmodule

//--- dv/seq_multiplier_tb.sv
/*
 * Signed sequential multiplier testbench
 * Runs directed vectors from a data file, then LCG random pairs,
 * and checks product, latency, handshake and result hold
 */

`timescale 1ns/10ps

module seq_multiplier_tb;

	// ========================================
	// Constants and DUT signals
	// ========================================

	localparam int MAX_VECTORS = 64;
	localparam int RANDOM_PAIRS = 200;
	// Edges from the accepting start to the edge that samples done
	localparam int LATENCY = mult_pkg::DW + 3;
	// Edges spent on one test with its start edge and idle cycles
	localparam int TEST_CYCLES = mult_pkg::DW + 3 + 4;

	logic clk;
	logic rst;
	logic start;
	logic signed [mult_pkg::DW-1:0] op_a;
	logic signed [mult_pkg::DW-1:0] op_b;
	logic busy;
	logic done;
	logic signed [mult_pkg::PW-1:0] product;

	// Each word holds mode, op_a, op_b and the expected product from the top bit down
	logic [35:0] test_vectors [0:MAX_VECTORS-1];

	int n_file;
	int test_count;
	int fail_count;
	int error_count;
	int cycle_count;
	int cycle_limit;
	// Product the DUT must keep showing until the next done
	logic signed [mult_pkg::PW-1:0] last_product;

	seq_multiplier_top seq_multiplier_top_i
	(
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.op_a    (op_a),
		.op_b    (op_b),
		.busy    (busy),
		.done    (done),
		.product (product)
	);

	// 40 ns clock period
	always #20 clk = ~clk;

	// The run limit is armed once the vector count is known
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout: run went past %0d cycles, control state %s", cycle_limit,
				seq_multiplier_top_i.mult_control_unit_i.state.name());
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ========================================
	// Compare tasks
	// ========================================

	task automatic check_product(input string name, input logic signed [mult_pkg::PW-1:0] got,
		input logic signed [mult_pkg::PW-1:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp)
		begin
			$display("MISMATCH at %0t: done latency got %0d expected %0d", $time, got, exp);
			error_count++;
		end
	endtask

	// A missing done mostly means the FSM is stuck, so the report names the state it sits in
	task automatic check_state_idle(input mult_pkg::ctrl_state_e got, input int cycles);
		if (got != mult_pkg::IDLE)
			$display("Test %0d: done did not arrive within %0d cycles, control unit stuck in %s",
				test_count, cycles, got.name());
		else
			$display("Test %0d: done did not arrive within %0d cycles and the control unit is idle",
				test_count, cycles);
		error_count++;
	endtask

	// LCG step with the common 32-bit constants
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ========================================
	// One multiplication
	// ========================================

	// Mode 1 adds a second start with other operands while the DUT is busy
	task automatic run_test(input logic [3:0] mode, input logic signed [mult_pkg::DW-1:0] a,
		input logic signed [mult_pkg::DW-1:0] b, input logic signed [mult_pkg::PW-1:0] exp);
		int edges;
		int errors_before;
		logic seen_done;
		errors_before = error_count;
		edges = 0;
		seen_done = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		op_a <= a;
		op_b <= b;
		// Operands are dropped right after the accepting edge
		@(posedge clk);
		start <= 1'b0;
		op_a <= ~a;
		op_b <= ~b;
		while (!seen_done && edges <= LATENCY + 2)
		begin
			@(negedge clk);
			check_flag("busy", busy, 1'b1);
			if (done)
				seen_done = 1'b1;
			else
			begin
				check_product("product before done", product, last_product);
				@(posedge clk);
				edges++;
				if (mode == 4'd1 && edges == 3)
				begin
					start <= 1'b1;
					op_a <= a ^ 8'h5a;
					op_b <= b ^ 8'ha5;
				end
				else if (mode == 4'd1 && edges == 4)
					start <= 1'b0;
			end
		end
		if (!seen_done)
			check_state_idle(seq_multiplier_top_i.mult_control_unit_i.state, edges);
		else
		begin
			// done seen after edge N+edges is sampled at the next edge
			check_latency(edges + 1, LATENCY);
			check_product("product", product, exp);
		end
		last_product = exp;
		// done lasts one cycle and busy falls with it
		@(posedge clk);
		@(negedge clk);
		check_flag("done", done, 1'b0);
		check_flag("busy", busy, 1'b0);
		check_product("product after done", product, exp);
		repeat (2)
		begin
			@(posedge clk);
			@(negedge clk);
			check_flag("done", done, 1'b0);
			check_product("product while idle", product, exp);
		end
		if (error_count == errors_before)
			$display("Test %0d mode %0d: %0d * %0d = %0d ok", test_count, mode, a, b, exp);
		else
		begin
			$display("Test %0d mode %0d: %0d * %0d = %0d FAILED", test_count, mode, a, b, exp);
			fail_count++;
		end
		test_count++;
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial
	begin
		int i;
		logic [31:0] seed;
		logic signed [mult_pkg::DW-1:0] ra;
		logic signed [mult_pkg::DW-1:0] rb;
		logic signed [mult_pkg::PW-1:0] rexp;
		clk = 1'b0;
		rst = 1'b0;
		start = 1'b0;
		op_a = '0;
		op_b = '0;
		test_count = 0;
		fail_count = 0;
		error_count = 0;
		cycle_count = 0;
		cycle_limit = 0;
		last_product = '0;
		seed = 32'h2291_6526;

		$readmemh("dv/mult_testdata.txt", test_vectors);
		// Mode F marks the end of the directed vectors
		n_file = 0;
		while (n_file < MAX_VECTORS && test_vectors[n_file][35:32] != 4'hf)
			n_file++;
		cycle_limit = (n_file + RANDOM_PAIRS) * TEST_CYCLES + 50;

		repeat (5) @(posedge clk);
		rst <= 1'b1;

		// Nothing may move before the first start
		@(negedge clk);
		check_flag("busy after reset", busy, 1'b0);
		check_flag("done after reset", done, 1'b0);
		check_product("product after reset", product, '0);

		for (i = 0; i < n_file; i++)
			run_test(test_vectors[i][35:32], test_vectors[i][31:24], test_vectors[i][23:16],
				test_vectors[i][15:0]);

		// Reference product from signed operands at product width
		for (i = 0; i < RANDOM_PAIRS; i++)
		begin
			seed = lcg_next(seed);
			ra = seed[23:16];
			rb = seed[15:8];
			rexp = ra * rb;
			run_test(4'd0, ra, rb, rexp);
		end

		$display("Tests run %0d, passed %0d, failed %0d, check errors %0d", test_count,
			test_count - fail_count, fail_count, error_count);
		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- dv/mult_testdata.txt
// Columns: mode_opa_opb_product in hex, mode 1 adds a start while busy
// The product is the signed 16-bit result, mode F ends the list
0_00_00_0000
0_00_7F_0000
0_01_01_0001
0_FF_FF_0001
0_01_FF_FFFF
0_FF_01_FFFF
0_80_80_4000
0_80_7F_C080
0_7F_7F_3F01
0_7F_80_C080
0_80_01_FF80
0_80_FF_0080
0_05_FD_FFF1
0_F6_F9_0046
0_0C_0D_009C
1_03_04_000C
1_E0_10_FE00
1_2A_9C_EF98
0_55_AA_E372
F_00_00_0000

//--- files.f
hw/mult_pkg.sv
hw/mult_control_unit.sv
hw/sign_resolver.sv
hw/operand_register.sv
hw/sweep_sequential_adder.sv
hw/seq_multiplier_top.sv
dv/seq_multiplier_tb.sv

//--- Bender.yml
package:
  name: seq_multiplier

dependencies: {}

sources:
  # Design sources in compile order
  - files:
      - hw/mult_pkg.sv
      - hw/mult_control_unit.sv
      - hw/sign_resolver.sv
      - hw/operand_register.sv
      - hw/sweep_sequential_adder.sv
      - hw/seq_multiplier_top.sv

  # Testbench
  - target: test
    files:
      - dv/seq_multiplier_tb.sv
